//--- run.sh
#!/usr/bin/env bash
# build and run the monitor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module mon_tb -o mon_tb_sim

./obj_dir/mon_tb_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"

//--- src/mem_bus_pkg.sv
package mem_bus_pkg;

	// one-cycle write request, one word
	typedef struct packed {
		logic        req;
		logic [29:0] word_adr;
		logic [31:0] data;
	} mem_wr_t;

	// one-cycle read request
	typedef struct packed {
		logic        req;
		logic [29:0] word_adr;
	} mem_rd_t;

	// responses back from the RAM
	typedef struct packed {
		// one cycle after a write request
		logic        wr_done;
		// two cycles after a read request
		logic        rd_valid;
		logic [31:0] rd_data;
	} mem_rsp_t;

endpackage

//--- src/mon_cmd_pkg.sv
package mon_cmd_pkg;

	// operation codes carried in the top bits of a command
	typedef enum logic [2:0] {
		SET_WADR   = 3'd0,
		WRITE_DATA = 3'd1,
		SET_RSTART = 3'd2,
		SET_REND   = 3'd3,
		STOP       = 3'd4,
		CLEAR      = 3'd5,
		PRINT_PC   = 3'd6
	} mon_cmd_e;

	// operand seen as a word address
	typedef struct packed {
		logic [29:0] word_adr;
		logic [1:0]  byte_off;
	} mon_adr_t;

	// same operand word, address or raw data depending on the op
	typedef union packed {
		mon_adr_t    adr;
		logic [31:0] data;
	} mon_word_u;

	typedef struct packed {
		mon_cmd_e  op;
		mon_word_u operand;
	} mon_cmd_t;

	// outgoing word to the host link
	typedef struct packed {
		logic [31:0] data;
		// set for a program counter word
		logic        is_pc;
	} mon_snd_t;

endpackage

//--- src/mon_ctrl.sv
module mon_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mon_cmd_pkg::mon_cmd_t  cmd,
	input  logic                   cmd_valid,
	input  logic                   snd_ready,
	input  logic [31:0]            pc_data,
	input  logic                   write_busy,
	input  logic                   clear_running,
	input  logic                   dump_last,
	input  logic                   rd_valid,
	input  logic [31:0]            rd_data_held,
	output logic                   cmd_ready,
	output logic                   wadr_set,
	output logic                   wdata_en,
	output logic                   clear_start,
	output logic                   rstart_set,
	output logic                   rend_set,
	output logic                   rd_issue,
	output mon_cmd_pkg::mon_word_u command_word,
	output mon_cmd_pkg::mon_snd_t  snd,
	output logic                   snd_valid,
	output logic                   dump_running
);
	import mon_cmd_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RD_WAIT,
		SEND,
		PC_SEND
	} state_e;

	state_e      state;
	state_e      state_nxt;
	logic        cmd_acc;
	logic        stop_acc;
	logic        busy;
	logic        rd_inflight;
	logic [31:0] pc_held;

	assign dump_running = (state == RD_WAIT) || (state == SEND);
	assign snd_valid = (state == SEND) || (state == PC_SEND);

	// a read left over from a stopped dump also holds off new commands
	assign busy = write_busy || clear_running || rd_inflight || (state != IDLE);
	assign cmd_ready = !busy || (dump_running && (cmd.op == STOP));

	assign cmd_acc = cmd_valid && cmd_ready;
	assign stop_acc = cmd_acc && (cmd.op == STOP);

	// one-cycle strobes on acceptance
	assign wadr_set = cmd_acc && (cmd.op == SET_WADR);
	assign wdata_en = cmd_acc && (cmd.op == WRITE_DATA);
	assign clear_start = cmd_acc && (cmd.op == CLEAR);
	assign rstart_set = cmd_acc && (cmd.op == SET_RSTART);
	assign rend_set = cmd_acc && (cmd.op == SET_REND);
	assign command_word = cmd.operand;

	// end address doubles as dump start; next word once current one is taken
	assign rd_issue = rend_set ||
		((state == SEND) && snd_ready && !dump_last && !stop_acc);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (rend_set)
					state_nxt = RD_WAIT;
				else if (cmd_acc && (cmd.op == PRINT_PC))
					state_nxt = PC_SEND;
			end
			RD_WAIT: begin
				if (stop_acc)
					state_nxt = IDLE;
				else if (rd_valid)
					state_nxt = SEND;
			end
			SEND: begin
				if (stop_acc)
					state_nxt = IDLE;
				else if (snd_ready)
					state_nxt = dump_last ? IDLE : RD_WAIT;
			end
			PC_SEND: begin
				if (snd_ready)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			rd_inflight <= 1'b0;
		end else begin
			state <= state_nxt;
			if (rd_issue)
				rd_inflight <= 1'b1;
			else if (rd_valid)
				rd_inflight <= 1'b0;
		end
	end

	// pc sampled when the print is accepted
	always_ff @(posedge clk) begin
		if (cmd_acc && (cmd.op == PRINT_PC))
			pc_held <= pc_data;
	end

	always_comb begin
		snd.data = (state == PC_SEND) ? pc_held : rd_data_held;
		snd.is_pc = (state == PC_SEND);
	end

	// offered word must not change until taken, unless the dump is stopped
	a_snd_stable: assert property (@(posedge clk) disable iff (!rst_n)
		snd_valid && !snd_ready && !stop_acc |=> snd_valid && $stable(snd))
		else $error("snd changed under back-pressure");

	// engines and memory must be idle whenever a command strobe goes out
	a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(write_busy || clear_running || rd_inflight) |->
		!(wadr_set || wdata_en || clear_start || rstart_set || rend_set || rd_issue))
		else $error("command strobe while busy");

endmodule

//--- src/mon_dump_engine.sv
module mon_dump_engine (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rstart_set,
	input  logic                   rend_set,
	input  logic                   rd_issue,
	input  mon_cmd_pkg::mon_word_u command_word,
	input  logic                   rd_valid,
	input  logic [31:0]            rd_data,
	output mem_bus_pkg::mem_rd_t   mem_rd,
	output logic                   dump_last,
	output logic [31:0]            rd_data_held
);
	logic [29:0] rd_adr;
	logic [29:0] end_adr;
	logic [29:0] iss_adr;
	logic [29:0] cap_adr;
	logic        rd_req;

	// read address counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_adr <= '0;
		else if (rstart_set)
			rd_adr <= command_word.adr.word_adr;
		else if (rd_issue)
			rd_adr <= rd_adr + 30'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			end_adr <= '0;
		else if (rend_set)
			end_adr <= command_word.adr.word_adr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_req <= 1'b0;
		else
			rd_req <= rd_issue;
	end

	// address stays put until the next issue
	always_ff @(posedge clk) begin
		if (rd_issue)
			iss_adr <= rd_adr;
	end

	// keep the word and where it came from for the send stage
	always_ff @(posedge clk) begin
		if (rd_valid) begin
			rd_data_held <= rd_data;
			cap_adr <= iss_adr;
		end
	end

	// an end below the start still sends the first word
	assign dump_last = (cap_adr >= end_adr);

	always_comb begin
		mem_rd.req = rd_req;
		mem_rd.word_adr = iss_adr;
	end

endmodule

//--- src/mon_mem.sv
module mon_mem #(
	parameter int ADR_BITS = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mem_bus_pkg::mem_wr_t  mem_wr,
	input  mem_bus_pkg::mem_rd_t  mem_rd,
	output mem_bus_pkg::mem_rsp_t mem_rsp
);
	logic [31:0] ram [2**ADR_BITS];
	logic        wr_ack;
	logic        rd_v1;
	logic        rd_v2;
	logic [31:0] rd_d1;
	logic [31:0] rd_d2;

	// only the low address bits reach the array, so addresses wrap
	always_ff @(posedge clk) begin
		if (mem_wr.req)
			ram[mem_wr.word_adr[ADR_BITS-1:0]] <= mem_wr.data;
	end

	// two register stages on the read path
	always_ff @(posedge clk) begin
		if (mem_rd.req)
			rd_d1 <= ram[mem_rd.word_adr[ADR_BITS-1:0]];
		rd_d2 <= rd_d1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ack <= 1'b0;
			rd_v1 <= 1'b0;
			rd_v2 <= 1'b0;
		end else begin
			wr_ack <= mem_wr.req;
			rd_v1 <= mem_rd.req;
			rd_v2 <= rd_v1;
		end
	end

	always_comb begin
		mem_rsp.wr_done = wr_ack;
		mem_rsp.rd_valid = rd_v2;
		mem_rsp.rd_data = rd_d2;
	end

	// write and dump engines share the RAM, one request at a time
	a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_wr.req && mem_rd.req))
		else $error("read and write request in the same cycle");

endmodule

//--- src/mon_top.sv
module mon_top #(
	parameter int ADR_BITS = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mon_cmd_pkg::mon_cmd_t cmd,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	input  logic [31:0]           pc_data,
	output mon_cmd_pkg::mon_snd_t snd,
	output logic                  snd_valid,
	input  logic                  snd_ready,
	output logic                  dump_running,
	output logic                  clear_running
);
	import mon_cmd_pkg::*;
	import mem_bus_pkg::*;

	mon_word_u   command_word;
	logic        wadr_set;
	logic        wdata_en;
	logic        clear_start;
	logic        rstart_set;
	logic        rend_set;
	logic        rd_issue;
	logic        write_busy;
	logic        dump_last;
	logic [31:0] rd_data_held;
	mem_wr_t     mem_wr;
	mem_rd_t     mem_rd;
	mem_rsp_t    mem_rsp;

	mon_ctrl u_mon_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.snd_ready    (snd_ready),
		.pc_data      (pc_data),
		.write_busy   (write_busy),
		.clear_running(clear_running),
		.dump_last    (dump_last),
		.rd_valid     (mem_rsp.rd_valid),
		.rd_data_held (rd_data_held),
		.cmd_ready    (cmd_ready),
		.wadr_set     (wadr_set),
		.wdata_en     (wdata_en),
		.clear_start  (clear_start),
		.rstart_set   (rstart_set),
		.rend_set     (rend_set),
		.rd_issue     (rd_issue),
		.command_word (command_word),
		.snd          (snd),
		.snd_valid    (snd_valid),
		.dump_running (dump_running)
	);

	mon_write_engine #(
		.ADR_BITS(ADR_BITS)
	) u_mon_write_engine (
		.clk          (clk),
		.rst_n        (rst_n),
		.wadr_set     (wadr_set),
		.wdata_en     (wdata_en),
		.clear_start  (clear_start),
		.command_word (command_word),
		.wr_done      (mem_rsp.wr_done),
		.mem_wr       (mem_wr),
		.write_busy   (write_busy),
		.clear_running(clear_running)
	);

	mon_dump_engine u_mon_dump_engine (
		.clk         (clk),
		.rst_n       (rst_n),
		.rstart_set  (rstart_set),
		.rend_set    (rend_set),
		.rd_issue    (rd_issue),
		.command_word(command_word),
		.rd_valid    (mem_rsp.rd_valid),
		.rd_data     (mem_rsp.rd_data),
		.mem_rd      (mem_rd),
		.dump_last   (dump_last),
		.rd_data_held(rd_data_held)
	);

	mon_mem #(
		.ADR_BITS(ADR_BITS)
	) u_mon_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.mem_wr (mem_wr),
		.mem_rd (mem_rd),
		.mem_rsp(mem_rsp)
	);

endmodule

//--- src/mon_write_engine.sv
module mon_write_engine #(
	parameter int ADR_BITS = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wadr_set,
	input  logic                   wdata_en,
	input  logic                   clear_start,
	input  mon_cmd_pkg::mon_word_u command_word,
	input  logic                   wr_done,
	output mem_bus_pkg::mem_wr_t   mem_wr,
	output logic                   write_busy,
	output logic                   clear_running
);
	logic [29:0]       wadr_cnt;
	logic [ADR_BITS:0] clr_cnt;
	logic              clr_next;
	logic              clr_issue;
	logic              wr_req;
	logic              wr_pend;
	logic [29:0]       wr_adr;
	logic [31:0]       wr_data;

	// next clear word goes out on the ack of the previous one
	assign clr_next = clear_running && wr_done && !clr_cnt[ADR_BITS];
	assign clr_issue = clear_start || clr_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wadr_cnt <= '0;
		else if (wadr_set)
			wadr_cnt <= command_word.adr.word_adr;
		else if (wdata_en)
			wadr_cnt <= wadr_cnt + 30'd1;
	end

	// top bit of clr_cnt marks all words issued
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clear_running <= 1'b0;
			clr_cnt <= '0;
		end else if (clear_start) begin
			clear_running <= 1'b1;
			clr_cnt <= (ADR_BITS + 1)'(1);
		end else if (clear_running && wr_done) begin
			if (clr_cnt[ADR_BITS])
				clear_running <= 1'b0;
			else
				clr_cnt <= clr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_req <= 1'b0;
			wr_pend <= 1'b0;
		end else begin
			wr_req <= wdata_en || clr_issue;
			if (wr_req)
				wr_pend <= 1'b1;
			else if (wr_done)
				wr_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (clr_issue) begin
			wr_adr <= clear_start ? 30'd0 : 30'(clr_cnt[ADR_BITS-1:0]);
			wr_data <= '0;
		end else if (wdata_en) begin
			wr_adr <= wadr_cnt;
			wr_data <= command_word.data;
		end
	end

	assign write_busy = wr_req || wr_pend;

	always_comb begin
		mem_wr.req = wr_req;
		mem_wr.word_adr = wr_adr;
		mem_wr.data = wr_data;
	end

	a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
		wr_pend |-> !wr_req)
		else $error("write request while a write is pending");

endmodule

//--- verif/mon_tb.sv
module mon_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import mon_cmd_pkg::*;

	localparam int ADR_BITS = 4;
	localparam int WORDS = 2 ** ADR_BITS;
	localparam int MAX_VEC = 64;

	logic        clk = 1'b0;
	logic        rst_n;
	mon_cmd_t    cmd;
	logic        cmd_valid;
	logic        cmd_ready;
	logic [31:0] pc_data = 32'h0000_1000;
	mon_snd_t    snd;
	logic        snd_valid;
	logic        snd_ready = 1'b0;
	logic        dump_running;
	logic        clear_running;

	logic [31:0] vec_mem [0:2*MAX_VEC-1];
	int          num_vec = 0;
	logic [31:0] lcg_state = 32'ha8c9;

	// reference memory
	logic [31:0] model_mem [WORDS];
	logic [29:0] model_wadr = '0;
	logic [29:0] model_rstart = '0;
	// expected words as {data, is_pc}
	logic [32:0] exp_q [$];

	int          mismatch_cnt = 0;
	int          fail_cnt = 0;
	int          words_checked = 0;
	int          clear_starts = 0;
	int          clear_ends = 0;
	int          clear_cycles = 0;
	logic        clear_was_high = 1'b0;
	logic        clear_check = 1'b0;
	logic        dump_end_check = 1'b0;
	logic        stop_check = 1'b0;

	mon_top #(
		.ADR_BITS(ADR_BITS)
	) u_mon_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.pc_data      (pc_data),
		.snd          (snd),
		.snd_valid    (snd_valid),
		.snd_ready    (snd_ready),
		.dump_running (dump_running),
		.clear_running(clear_running)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// host link readiness, and a core that keeps running
	always @(posedge clk) begin
		lcg_state = lcg_next(lcg_state);
		snd_ready <= (lcg_state[17:16] != 2'b00);
		pc_data <= pc_data + 32'd4;
	end

	task automatic issue_cmd(input logic [2:0] op, input logic [31:0] operand);
		if (op == STOP) begin
			// let the dump get under way first
			cmd_valid <= 1'b0;
			repeat (operand) @(posedge clk);
		end
		cmd.op <= mon_cmd_e'(op);
		cmd.operand.data <= operand;
		cmd_valid <= 1'b1;
		do
			@(negedge clk);
		while (!cmd_ready);
		@(posedge clk);
	endtask

	task automatic check_word();
		logic [32:0] exp_word;
		if (exp_q.size() == 0) begin
			fail_cnt++;
			$display("%t: a word arrived on snd when none was due (data %h)", $time, snd.data);
		end else begin
			exp_word = exp_q.pop_front();
			words_checked++;
			if (snd.data !== exp_word[32:1]) begin
				mismatch_cnt++;
				$display("MISMATCH at %t: snd.data expected %h got %h",
					$time, exp_word[32:1], snd.data);
			end
			if (snd.is_pc !== exp_word[0]) begin
				mismatch_cnt++;
				$display("MISMATCH at %t: snd.is_pc expected %b got %b",
					$time, exp_word[0], snd.is_pc);
			end
			// high for dump words, low for a program counter word
			if (dump_running !== !exp_word[0]) begin
				mismatch_cnt++;
				$display("MISMATCH at %t: dump_running expected %b got %b",
					$time, !exp_word[0], dump_running);
			end
			if (!exp_word[0] && exp_q.size() == 0)
				dump_end_check = 1'b1;
		end
	endtask

	task automatic apply_cmd(input mon_cmd_e op, input logic [31:0] operand);
		logic [29:0] adr;
		case (op)
			SET_WADR: model_wadr = operand[31:2];
			WRITE_DATA: begin
				model_mem[model_wadr[ADR_BITS-1:0]] = operand;
				model_wadr = model_wadr + 30'd1;
			end
			SET_RSTART: model_rstart = operand[31:2];
			SET_REND: begin
				// start word always goes out, then on up to the end
				adr = model_rstart;
				exp_q.push_back({model_mem[adr[ADR_BITS-1:0]], 1'b0});
				while (adr < operand[31:2]) begin
					adr = adr + 30'd1;
					exp_q.push_back({model_mem[adr[ADR_BITS-1:0]], 1'b0});
				end
			end
			STOP: begin
				if (!dump_running) begin
					fail_cnt++;
					$display("%t: STOP was accepted while no dump was running", $time);
				end
				exp_q.delete();
				stop_check = 1'b1;
			end
			CLEAR: begin
				for (int i = 0; i < WORDS; i++)
					model_mem[i] = '0;
				clear_starts++;
				clear_check = 1'b1;
			end
			PRINT_PC: exp_q.push_back({pc_data, 1'b1});
			default: begin
				fail_cnt++;
				$display("%t: unknown command code %0d was accepted", $time, op);
			end
		endcase
	endtask

	// sampled mid-cycle so a handshake seen here completes at the next rise
	always @(negedge clk) begin
		if (rst_n) begin
			if (dump_end_check) begin
				if (dump_running) begin
					fail_cnt++;
					$display("%t: dump_running still high after the last dump word", $time);
				end
				dump_end_check = 1'b0;
			end
			if (stop_check) begin
				if (dump_running) begin
					fail_cnt++;
					$display("%t: dump_running still high after STOP", $time);
				end
				stop_check = 1'b0;
			end
			if (clear_check) begin
				if (!clear_running) begin
					fail_cnt++;
					$display("%t: clear_running did not rise after CLEAR", $time);
				end
				clear_check = 1'b0;
			end
			if (clear_running) begin
				clear_cycles++;
			end else if (clear_was_high) begin
				clear_ends++;
				// two cycles per word
				if (clear_cycles < 2 * WORDS || clear_cycles > 2 * WORDS + 2) begin
					fail_cnt++;
					$display("%t: clear took %0d cycles, about %0d were due",
						$time, clear_cycles, 2 * WORDS);
				end
				clear_cycles = 0;
			end
			clear_was_high = clear_running;
			if (snd_valid && snd_ready)
				check_word();
			if (cmd_valid && cmd_ready)
				apply_cmd(cmd.op, cmd.operand.data);
		end
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		rst_n = 1'b0;
		cmd = '0;
		cmd_valid = 1'b0;
		for (int i = 0; i < 2 * MAX_VEC; i++)
			vec_mem[i] = '1;
		$readmemh("verif/mon_vectors.txt", vec_mem);
		while (num_vec < MAX_VEC && vec_mem[2 * num_vec] !== 32'hffff_ffff)
			num_vec++;
		if (num_vec == 0) begin
			fail_cnt++;
			$display("no command vectors were read from verif/mon_vectors.txt");
		end

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		for (int n = 0; n < num_vec; n++)
			issue_cmd(vec_mem[2 * n][2:0], vec_mem[2 * n + 1]);
		cmd_valid <= 1'b0;

		// drain the last dump, then watch for stray words
		do
			@(negedge clk);
		while (exp_q.size() != 0 || dump_running || clear_running || !cmd_ready);
		repeat (10) @(negedge clk);

		if (clear_ends != clear_starts) begin
			fail_cnt++;
			$display("%0d clears started but only %0d finished", clear_starts, clear_ends);
		end

		$display("errors: %0d mismatches, %0d other failures, %0d words checked",
			mismatch_cnt, fail_cnt, words_checked);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		#1;
		repeat (num_vec * 200) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", num_vec * 200);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- verif/mon_vectors.txt
// columns: op code (0 SET_WADR .. 6 PRINT_PC), operand word, both hex
// the operand of a STOP line is the idle gap in cycles before it is sent
5 00000000 // clear all words
2 00000000
3 0000003c // dump 0..15, all zero
0 00000010 // write words 4..7
1 11110004
1 22220005
1 33330006
1 44440007
2 0000000c
3 00000020 // dump 3..8
6 00000000
0 00000078 // word 30 wraps onto 14
1 aaaa000e
1 bbbb000f
1 cccc0000
1 dddd0001
2 00000078
3 00000084 // dump 30..33
2 00000014
3 00000008 // end below start, one word
2 00000000
3 0000003c
4 00000014 // stop after 20 idle cycles
6 00000000
2 00000030
3 00000044 // dump 12..17 across the wrap

//--- vlog.f
src/mon_cmd_pkg.sv
src/mem_bus_pkg.sv
src/mon_ctrl.sv
src/mon_write_engine.sv
src/mon_dump_engine.sv
src/mon_mem.sv
src/mon_top.sv
verif/mon_tb.sv
